// File: list.f
design/tcdm_pkg.sv
design/tcdm_bank_if.sv
design/tcdm_master_port.sv
design/tcdm_bank_arbiter.sv
design/tcdm_amo_bank.sv
design/tcdm_interconnect_top.sv
verification/tb_tcdm_interconnect.sv

// File: Bender.yml
package:
  name: tcdm_interconnect

sources:
  - design/tcdm_pkg.sv
  - design/tcdm_bank_if.sv
  - design/tcdm_master_port.sv
  - design/tcdm_bank_arbiter.sv
  - design/tcdm_amo_bank.sv
  - design/tcdm_interconnect_top.sv
  - target: simulation
    files:
      - verification/tb_tcdm_interconnect.sv

// File: verification/tb_tcdm_interconnect.sv
// one request in flight per master; memory words are compared only after the run has written them
`timescale 1ns/1ps

module tb_tcdm_interconnect;

  localparam int NUM_MASTERS   = 4;
  localparam int NUM_BANKS     = 4;
  localparam int DATA_WIDTH    = 32;
  localparam int ADDR_WIDTH    = 32;
  localparam int ROW_WIDTH     = 6;
  localparam int BE_WIDTH      = DATA_WIDTH / 8;
  localparam int AW            = tcdm_pkg::ATOP_WIDTH;
  localparam int IDX_BITS      = $clog2(NUM_BANKS) + ROW_WIDTH;
  localparam int CLK_PERIOD    = 40;
  localparam int DRIVE_DELAY   = 2;
  localparam int STALL_MAX     = 20;
  localparam int FILL_WORDS    = 32;
  localparam int RAND_OPS      = 40;
  localparam int SAME_BANK_OPS = 2;

  localparam logic [AW-1:0] AT_NONE = '0;
  localparam logic [AW-1:0] AT_ADD  = {1'b1, tcdm_pkg::ATOP_ADD};
  localparam logic [AW-1:0] AT_SWAP = {1'b1, tcdm_pkg::ATOP_SWAP};
  localparam logic [AW-1:0] AT_XOR  = {1'b1, tcdm_pkg::ATOP_XOR};
  localparam logic [AW-1:0] AT_OR   = {1'b1, tcdm_pkg::ATOP_OR};
  localparam logic [AW-1:0] AT_AND  = {1'b1, tcdm_pkg::ATOP_AND};
  localparam logic [AW-1:0] AT_MIN  = {1'b1, tcdm_pkg::ATOP_MIN};
  localparam logic [AW-1:0] AT_MAX  = {1'b1, tcdm_pkg::ATOP_MAX};
  localparam logic [AW-1:0] AT_MINU = {1'b1, tcdm_pkg::ATOP_MINU};
  localparam logic [AW-1:0] AT_MAXU = {1'b1, tcdm_pkg::ATOP_MAXU};
  localparam logic [AW-1:0] AT_ALL [9] = '{AT_ADD, AT_SWAP, AT_XOR, AT_OR, AT_AND,
                                           AT_MIN, AT_MAX, AT_MINU, AT_MAXU};

  typedef struct {
    logic                  we;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
    logic [BE_WIDTH-1:0]   be;
    logic [AW-1:0]         atop;
    // table entries carry a hand-computed expected word
    logic                  fixed;
    logic [DATA_WIDTH-1:0] expected;
  } op_t;

  logic                                   clk;
  logic                                   rst_n;
  logic [NUM_MASTERS-1:0]                 req;
  logic [NUM_MASTERS-1:0][ADDR_WIDTH-1:0] addr;
  logic [NUM_MASTERS-1:0]                 we;
  logic [NUM_MASTERS-1:0][DATA_WIDTH-1:0] wdata;
  logic [NUM_MASTERS-1:0][BE_WIDTH-1:0]   be;
  logic [NUM_MASTERS-1:0][AW-1:0]         atop;
  logic [NUM_MASTERS-1:0]                 gnt;
  logic [NUM_MASTERS-1:0]                 r_valid;
  logic [NUM_MASTERS-1:0][DATA_WIDTH-1:0] r_rdata;

  // word model indexed by bank and row together
  logic [DATA_WIDTH-1:0] model_mem [2 ** IDX_BITS];
  op_t                   table_ops [$];
  int                    table_master [$];
  string                 table_names [$];
  op_t                   ops [NUM_MASTERS][RAND_OPS];
  int                    op_cnt [NUM_MASTERS];
  // grants per master among the first NUM_MASTERS grants of a phase
  int                    grant_cnt [NUM_MASTERS];
  int                    run_len;

  tcdm_interconnect_top #(
    .NUM_MASTERS (NUM_MASTERS),
    .NUM_BANKS   (NUM_BANKS),
    .DATA_WIDTH  (DATA_WIDTH),
    .ADDR_WIDTH  (ADDR_WIDTH),
    .ROW_WIDTH   (ROW_WIDTH)
  ) tcdm_interconnect_top_inst (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .req_i     (req),
    .addr_i    (addr),
    .we_i      (we),
    .wdata_i   (wdata),
    .be_i      (be),
    .atop_i    (atop),
    .gnt_o     (gnt),
    .r_valid_o (r_valid),
    .r_rdata_o (r_rdata)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic op_t make_op(input logic w, input logic [ADDR_WIDTH-1:0] a,
                                  input logic [DATA_WIDTH-1:0] d, input logic [BE_WIDTH-1:0] b,
                                  input logic [AW-1:0] t, input logic fx,
                                  input logic [DATA_WIDTH-1:0] e);
    op_t op;
    op = '{we: w, addr: a, wdata: d, be: b, atop: t, fixed: fx, expected: e};
    return op;
  endfunction

  // offset bits dropped, bank bits low, row bits above them
  function automatic int word_index(input logic [ADDR_WIDTH-1:0] a);
    return int'(a[2 +: IDX_BITS]);
  endfunction

  function automatic logic [DATA_WIDTH-1:0] next_word(input logic [DATA_WIDTH-1:0] old,
                                                      input op_t op);
    logic [DATA_WIDTH-1:0] res;
    res = old;
    if (op.we) begin
      for (int b = 0; b < BE_WIDTH; b++) begin
        if (op.be[b]) begin
          res[8*b +: 8] = op.wdata[8*b +: 8];
        end
      end
    end
    // atomics replace the whole word and ignore the byte enables
    if (op.atop[AW-1]) begin
      case (op.atop[4:0])
        tcdm_pkg::ATOP_ADD:  res = old + op.wdata;
        tcdm_pkg::ATOP_SWAP: res = op.wdata;
        tcdm_pkg::ATOP_XOR:  res = old ^ op.wdata;
        tcdm_pkg::ATOP_OR:   res = old | op.wdata;
        tcdm_pkg::ATOP_AND:  res = old & op.wdata;
        tcdm_pkg::ATOP_MIN:  res = ($signed(old) < $signed(op.wdata)) ? old : op.wdata;
        tcdm_pkg::ATOP_MAX:  res = ($signed(old) > $signed(op.wdata)) ? old : op.wdata;
        tcdm_pkg::ATOP_MINU: res = (old < op.wdata) ? old : op.wdata;
        tcdm_pkg::ATOP_MAXU: res = (old > op.wdata) ? old : op.wdata;
        default: ;
      endcase
    end
    return res;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] expected,
                             input logic [DATA_WIDTH-1:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("Fail %s: expected 0x%08h, actual 0x%08h", name, expected, actual));
    end
  endtask

  task automatic add_step(input string name, input int m, input logic w,
                          input logic [ADDR_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] d,
                          input logic [BE_WIDTH-1:0] b, input logic [AW-1:0] t,
                          input logic [DATA_WIDTH-1:0] e);
    table_names.push_back(name);
    table_master.push_back(m);
    table_ops.push_back(make_op(w, a, d, b, t, 1'b1, e));
  endtask

  task automatic queue_op(input int m, input op_t op);
    ops[m][op_cnt[m]] = op;
    op_cnt[m]++;
  endtask

  task automatic drive_op(input int m, input op_t op);
    req[m]   = 1'b1;
    we[m]    = op.we;
    addr[m]  = op.addr;
    wdata[m] = op.wdata;
    be[m]    = op.be;
    atop[m]  = op.atop;
  endtask

  // runs the queued ops of all masters in parallel and checks every response
  task automatic run_parallel(input string phase);
    int                    next_idx [NUM_MASTERS];
    logic                  busy [NUM_MASTERS];
    logic                  pend [NUM_MASTERS];
    logic                  pend_chk [NUM_MASTERS];
    logic [DATA_WIDTH-1:0] pend_exp [NUM_MASTERS];
    string                 pend_name [NUM_MASTERS];
    op_t                   cur [NUM_MASTERS];
    int                    left;
    int                    inflight;
    int                    stall;
    int                    w;
    int                    grants_seen;
    logic                  granted;
    left        = 0;
    inflight    = 0;
    stall       = 0;
    grants_seen = 0;
    for (int m = 0; m < NUM_MASTERS; m++) begin
      next_idx[m]  = 0;
      busy[m]      = 1'b0;
      pend[m]      = 1'b0;
      grant_cnt[m] = 0;
      left += op_cnt[m];
    end
    @(posedge clk);
    #DRIVE_DELAY;
    while (left > 0 || inflight > 0) begin
      for (int m = 0; m < NUM_MASTERS; m++) begin
        if (!busy[m] && next_idx[m] < op_cnt[m]) begin
          cur[m]  = ops[m][next_idx[m]];
          busy[m] = 1'b1;
          next_idx[m]++;
          drive_op(m, cur[m]);
        end else if (!busy[m]) begin
          req[m] = 1'b0;
        end
      end
      @(negedge clk);
      granted = 1'b0;
      for (int m = 0; m < NUM_MASTERS; m++) begin
        check_value($sformatf("%s m%0d r_valid", phase, m), pend[m], r_valid[m]);
        if (pend[m] && pend_chk[m]) begin
          check_value(pend_name[m], pend_exp[m], r_rdata[m]);
        end
        if (pend[m]) begin
          inflight--;
        end
        pend[m] = 1'b0;
        if (busy[m] && gnt[m]) begin
          w            = word_index(cur[m].addr);
          pend_exp[m]  = cur[m].fixed ? cur[m].expected : model_mem[w];
          pend_chk[m]  = !cur[m].we || cur[m].atop[AW-1];
          pend_name[m] = $sformatf("%s m%0d op%0d", phase, m, next_idx[m] - 1);
          model_mem[w] = next_word(model_mem[w], cur[m]);
          pend[m]      = 1'b1;
          busy[m]      = 1'b0;
          granted      = 1'b1;
          inflight++;
          left--;
          if (grants_seen < NUM_MASTERS) begin
            grant_cnt[m]++;
          end
          grants_seen++;
        end else if (!busy[m]) begin
          check_value($sformatf("%s m%0d idle gnt", phase, m), 1'b0, gnt[m]);
        end
      end
      stall = granted ? 0 : stall + 1;
      if (stall > STALL_MAX) begin
        abort_run($sformatf("%s: no grant within %0d cycles", phase, STALL_MAX));
      end
      @(posedge clk);
      #DRIVE_DELAY;
    end
    req = '0;
  endtask

  // watchdog sized from the number of requests in the run
  initial begin
    wait (run_len > 0);
    #(run_len * 10 * CLK_PERIOD);
    abort_run($sformatf("timeout: run did not finish within %0d ns", run_len * 10 * CLK_PERIOD));
  end

  initial begin
    op_t                   op;
    logic [ADDR_WIDTH-1:0] a;
    void'($urandom(48313));
    rst_n = 1'b0;
    req   = '0;
    addr  = '0;
    we    = '0;
    wdata = '0;
    be    = '0;
    atop  = '0;

    // full words across all banks and several rows, read back by other masters
    add_step("wr_b0_r0",   0, 1, 32'h00000000, 32'h11111111, 4'hF, AT_NONE, 32'h0);
    add_step("wr_b1_r0",   0, 1, 32'h00000004, 32'h22222222, 4'hF, AT_NONE, 32'h0);
    add_step("wr_b2_r0",   0, 1, 32'h00000008, 32'h33333333, 4'hF, AT_NONE, 32'h0);
    add_step("wr_b3_r0",   0, 1, 32'h0000000C, 32'h44444444, 4'hF, AT_NONE, 32'h0);
    add_step("wr_b0_r1",   0, 1, 32'h00000010, 32'h55555555, 4'hF, AT_NONE, 32'h0);
    add_step("wr_b1_r63",  0, 1, 32'h000003F4, 32'hA5A55A5A, 4'hF, AT_NONE, 32'h0);
    add_step("rd_b0_r0",   1, 0, 32'h00000000, 32'h0, 4'hF, AT_NONE, 32'h11111111);
    add_step("rd_b1_r0",   2, 0, 32'h00000004, 32'h0, 4'hF, AT_NONE, 32'h22222222);
    add_step("rd_b2_r0",   3, 0, 32'h00000008, 32'h0, 4'hF, AT_NONE, 32'h33333333);
    add_step("rd_b3_r0",   1, 0, 32'h0000000C, 32'h0, 4'hF, AT_NONE, 32'h44444444);
    add_step("rd_b0_r1",   2, 0, 32'h00000010, 32'h0, 4'hF, AT_NONE, 32'h55555555);
    add_step("rd_b1_r63",  3, 0, 32'h000003F4, 32'h0, 4'hF, AT_NONE, 32'hA5A55A5A);
    add_step("rd_alias",   1, 0, 32'h80000010, 32'h0, 4'hF, AT_NONE, 32'h55555555);
    add_step("wr_be_0101", 1, 1, 32'h00000000, 32'hAABBCCDD, 4'h5, AT_NONE, 32'h0);
    add_step("rd_be_0101", 2, 0, 32'h00000000, 32'h0, 4'hF, AT_NONE, 32'h11BB11DD);
    add_step("wr_be_1000", 2, 1, 32'h00000004, 32'h12345678, 4'h8, AT_NONE, 32'h0);
    add_step("rd_be_1000", 0, 0, 32'h00000004, 32'h0, 4'hF, AT_NONE, 32'h12222222);
    // atomic chain on one word, each old value is the previous result
    add_step("wr_amo",     0, 1, 32'h00000020, 32'h00000010, 4'hF, AT_NONE, 32'h0);
    add_step("amo_add",    1, 0, 32'h00000020, 32'h00000005, 4'hF, AT_ADD,  32'h00000010);
    add_step("rd_add",     2, 0, 32'h00000020, 32'h0, 4'hF, AT_NONE, 32'h00000015);
    add_step("amo_swap",   3, 0, 32'h00000020, 32'hF0F00F0F, 4'hF, AT_SWAP, 32'h00000015);
    add_step("amo_xor",    0, 0, 32'h00000020, 32'hFFFF0000, 4'hF, AT_XOR,  32'hF0F00F0F);
    add_step("amo_or",     1, 0, 32'h00000020, 32'h30000000, 4'hF, AT_OR,   32'h0F0F0F0F);
    add_step("amo_and",    2, 0, 32'h00000020, 32'h00FFFFF0, 4'hF, AT_AND,  32'h3F0F0F0F);
    add_step("amo_min",    3, 0, 32'h00000020, 32'h80000001, 4'hF, AT_MIN,  32'h000F0F00);
    add_step("amo_max",    0, 0, 32'h00000020, 32'h00000100, 4'hF, AT_MAX,  32'h80000001);
    add_step("amo_minu",   1, 0, 32'h00000020, 32'hFFFFFFF0, 4'hF, AT_MINU, 32'h00000100);
    add_step("amo_maxu",   2, 0, 32'h00000020, 32'h80000000, 4'hF, AT_MAXU, 32'h00000100);
    add_step("rd_maxu",    3, 0, 32'h00000020, 32'h0, 4'hF, AT_NONE, 32'h80000000);

    run_len = table_ops.size() + FILL_WORDS + SAME_BANK_OPS * NUM_MASTERS + 1
              + NUM_MASTERS * RAND_OPS;
    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    repeat (2) begin
      @(negedge clk);
      check_value("reset gnt", '0, gnt);
      check_value("reset r_valid", '0, r_valid);
    end

    foreach (table_ops[i]) begin
      op_cnt = '{default: 0};
      queue_op(table_master[i], table_ops[i]);
      run_parallel(table_names[i]);
    end

    // every word the random traffic touches gets a known value first
    op_cnt = '{default: 0};
    for (int i = 0; i < FILL_WORDS; i++) begin
      a = ADDR_WIDTH'(4 * i);
      queue_op(i % NUM_MASTERS,
               make_op(1, a, (a * 32'h9E3779B1) ^ {a[15:0], a[31:16]}, '1, AT_NONE, 0, '0));
    end
    run_parallel("fill");

    // all masters hit bank 1 in the same cycle and keep asking again right away
    op_cnt = '{default: 0};
    for (int m = 0; m < NUM_MASTERS; m++) begin
      for (int k = 0; k < SAME_BANK_OPS; k++) begin
        queue_op(m, make_op(0, 32'h34, 32'((m + 1) * 32'h00010001 + k), '1, AT_ADD, 0, '0));
      end
    end
    run_parallel("same_bank");
    for (int m = 0; m < NUM_MASTERS; m++) begin
      check_value($sformatf("same_bank grants m%0d", m), 1, grant_cnt[m]);
    end
    op_cnt = '{default: 0};
    queue_op(NUM_MASTERS - 1, make_op(0, 32'h34, '0, '1, AT_NONE, 0, '0));
    run_parallel("same_bank_sum");

    op_cnt = '{default: 0};
    for (int m = 0; m < NUM_MASTERS; m++) begin
      for (int k = 0; k < RAND_OPS; k++) begin
        a = $urandom;
        a[2 +: IDX_BITS] = IDX_BITS'($urandom % FILL_WORDS);
        case ($urandom % 4)
          0: op = make_op(0, a, $urandom, '1, AT_NONE, 0, '0);
          1: op = make_op(1, a, $urandom, BE_WIDTH'($urandom % (2 ** BE_WIDTH - 1) + 1),
                          AT_NONE, 0, '0);
          default: op = make_op(0, a, $urandom, '1, AT_ALL[$urandom % 9], 0, '0);
        endcase
        queue_op(m, op);
      end
    end
    run_parallel("random");

    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: design/tcdm_interconnect_top.sv
// NUM_BANKS must be a power of two; address bits above the row field are ignored
`timescale 1ns/1ps

module tcdm_interconnect_top #(
  parameter int  NUM_MASTERS    = 4,
  parameter int  NUM_BANKS      = 4,
  parameter int  DATA_WIDTH     = 32,
  parameter int  ADDR_WIDTH     = 32,
  parameter int  ROW_WIDTH      = 6,
  localparam int BANK_SEL_WIDTH = $clog2(NUM_BANKS),
  localparam int BE_WIDTH       = DATA_WIDTH / 8
) (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,
  input  logic [NUM_MASTERS-1:0]                           req_i,
  input  logic [NUM_MASTERS-1:0][ADDR_WIDTH-1:0]           addr_i,
  input  logic [NUM_MASTERS-1:0]                           we_i,
  input  logic [NUM_MASTERS-1:0][DATA_WIDTH-1:0]           wdata_i,
  input  logic [NUM_MASTERS-1:0][BE_WIDTH-1:0]             be_i,
  input  logic [NUM_MASTERS-1:0][tcdm_pkg::ATOP_WIDTH-1:0] atop_i,
  output logic [NUM_MASTERS-1:0]                           gnt_o,
  output logic [NUM_MASTERS-1:0]                           r_valid_o,
  output logic [NUM_MASTERS-1:0][DATA_WIDTH-1:0]           r_rdata_o
);

  // master side request bundle
  logic [NUM_MASTERS-1:0]                     master_req;
  logic [NUM_MASTERS-1:0][BANK_SEL_WIDTH-1:0] master_bank_sel;
  logic [NUM_MASTERS-1:0][ROW_WIDTH-1:0]      master_row;

  // grants as produced per bank and as seen per master
  logic [NUM_BANKS-1:0][NUM_MASTERS-1:0]      bank_gnt;
  logic [NUM_MASTERS-1:0][NUM_BANKS-1:0]      master_gnt;

  logic [NUM_BANKS-1:0][DATA_WIDTH-1:0]       bank_rdata;

  for (genvar m = 0; m < NUM_MASTERS; m++) begin : gen_master
    for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_gnt_transpose
      assign master_gnt[m][b] = bank_gnt[b][m];
    end

    tcdm_master_port #(
      .NUM_BANKS  (NUM_BANKS),
      .DATA_WIDTH (DATA_WIDTH),
      .ADDR_WIDTH (ADDR_WIDTH),
      .ROW_WIDTH  (ROW_WIDTH)
    ) tcdm_master_port_inst (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .req_i        (req_i[m]),
      .we_i         (we_i[m]),
      .addr_i       (addr_i[m]),
      .wdata_i      (wdata_i[m]),
      .be_i         (be_i[m]),
      .atop_i       (atop_i[m]),
      .bank_req_o   (master_req[m]),
      .bank_sel_o   (master_bank_sel[m]),
      .row_o        (master_row[m]),
      .bank_gnt_i   (master_gnt[m]),
      .bank_rdata_i (bank_rdata),
      .gnt_o        (gnt_o[m]),
      .r_valid_o    (r_valid_o[m]),
      .r_rdata_o    (r_rdata_o[m])
    );
  end

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    tcdm_bank_if #(
      .DATA_WIDTH (DATA_WIDTH),
      .ROW_WIDTH  (ROW_WIDTH)
    ) bank_if ();

    tcdm_bank_arbiter #(
      .NUM_MASTERS (NUM_MASTERS),
      .NUM_BANKS   (NUM_BANKS),
      .DATA_WIDTH  (DATA_WIDTH),
      .ROW_WIDTH   (ROW_WIDTH),
      .BANK_ID     (b)
    ) tcdm_bank_arbiter_inst (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .req_i      (master_req),
      .bank_sel_i (master_bank_sel),
      .row_i      (master_row),
      .we_i       (we_i),
      .wdata_i    (wdata_i),
      .be_i       (be_i),
      .atop_i     (atop_i),
      .gnt_o      (bank_gnt[b]),
      .bank       (bank_if.arbiter)
    );

    tcdm_amo_bank #(
      .DATA_WIDTH (DATA_WIDTH),
      .ROW_WIDTH  (ROW_WIDTH)
    ) tcdm_amo_bank_inst (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .bank    (bank_if.bank)
    );

    assign bank_rdata[b] = bank_if.rdata;
  end

endmodule

// File: design/tcdm_amo_bank.sv
// single-port bank with registered read; atomics write the full word and block the bank a cycle
`timescale 1ns/1ps

module tcdm_amo_bank #(
  parameter int DATA_WIDTH = 32,
  parameter int ROW_WIDTH  = 6
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  tcdm_bank_if.bank bank
);

  localparam int BE_WIDTH = DATA_WIDTH / 8;
  localparam int DEPTH    = 2 ** ROW_WIDTH;

  logic [DATA_WIDTH-1:0] mem_q [DEPTH];
  logic [DATA_WIDTH-1:0] rdata_q;

  logic                  plain_write;
  logic                  is_atomic;

  // write-back state for a pending atomic
  logic                  wb_q;
  tcdm_pkg::amo_op_e     amo_q;
  logic [DATA_WIDTH-1:0] operand_q;
  logic [ROW_WIDTH-1:0]  row_q;

  logic [DATA_WIDTH-1:0] amo_result;
  logic                  signed_lt;
  logic                  unsigned_lt;

  assign is_atomic   = bank.amo != tcdm_pkg::AMO_NONE;
  assign plain_write = bank.req && bank.we && !is_atomic;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wb_q <= 1'b0;
    end else begin
      wb_q <= bank.req && is_atomic;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bank.req) begin
      amo_q     <= bank.amo;
      operand_q <= bank.wdata;
      row_q     <= bank.row;
    end
  end

  // old word is captured on every access, writes included
  always_ff @(posedge clk_i) begin
    if (bank.req) begin
      rdata_q <= mem_q[bank.row];
    end
    if (plain_write) begin
      for (int b = 0; b < BE_WIDTH; b++) begin
        if (bank.be[b]) begin
          mem_q[bank.row][8*b +: 8] <= bank.wdata[8*b +: 8];
        end
      end
    end else if (wb_q) begin
      mem_q[row_q] <= amo_result;
    end
  end

  assign signed_lt   = $signed(rdata_q) < $signed(operand_q);
  assign unsigned_lt = rdata_q < operand_q;

  // atomic ALU works on the old word read in the grant cycle
  always_comb begin
    case (amo_q)
      tcdm_pkg::AMO_SWAP: amo_result = operand_q;
      tcdm_pkg::AMO_ADD:  amo_result = rdata_q + operand_q;
      tcdm_pkg::AMO_AND:  amo_result = rdata_q & operand_q;
      tcdm_pkg::AMO_OR:   amo_result = rdata_q | operand_q;
      tcdm_pkg::AMO_XOR:  amo_result = rdata_q ^ operand_q;
      tcdm_pkg::AMO_MAX:  amo_result = signed_lt ? operand_q : rdata_q;
      tcdm_pkg::AMO_MAXU: amo_result = unsigned_lt ? operand_q : rdata_q;
      tcdm_pkg::AMO_MIN:  amo_result = signed_lt ? rdata_q : operand_q;
      tcdm_pkg::AMO_MINU: amo_result = unsigned_lt ? rdata_q : operand_q;
      default:            amo_result = rdata_q;
    endcase
  end

  assign bank.ready = !wb_q;
  assign bank.rdata = rdata_q;

  // the arbiter must hold off while the result is written back
  a_no_req_in_wb : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_q |-> !bank.req);

endmodule

// File: design/tcdm_bank_arbiter.sv
// round-robin over masters addressing this bank; nothing is granted while the bank is not ready
`timescale 1ns/1ps

module tcdm_bank_arbiter #(
  parameter int  NUM_MASTERS    = 4,
  parameter int  NUM_BANKS      = 4,
  parameter int  DATA_WIDTH     = 32,
  parameter int  ROW_WIDTH      = 6,
  parameter int  BANK_ID        = 0,
  localparam int BANK_SEL_WIDTH = $clog2(NUM_BANKS),
  localparam int BE_WIDTH       = DATA_WIDTH / 8
) (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  input  logic [NUM_MASTERS-1:0]                              req_i,
  input  logic [NUM_MASTERS-1:0][BANK_SEL_WIDTH-1:0]          bank_sel_i,
  input  logic [NUM_MASTERS-1:0][ROW_WIDTH-1:0]               row_i,
  input  logic [NUM_MASTERS-1:0]                              we_i,
  input  logic [NUM_MASTERS-1:0][DATA_WIDTH-1:0]              wdata_i,
  input  logic [NUM_MASTERS-1:0][BE_WIDTH-1:0]                be_i,
  input  logic [NUM_MASTERS-1:0][tcdm_pkg::ATOP_WIDTH-1:0]    atop_i,
  output logic [NUM_MASTERS-1:0]                              gnt_o,
  tcdm_bank_if.arbiter                                        bank
);

  localparam int MASTER_IDX_WIDTH = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

  logic [NUM_MASTERS-1:0]      hit;
  logic [MASTER_IDX_WIDTH-1:0] rr_q;
  logic [MASTER_IDX_WIDTH-1:0] win_idx;
  logic                        win_valid;
  int                          cand;

  for (genvar m = 0; m < NUM_MASTERS; m++) begin : gen_hit
    assign hit[m] = req_i[m] && (bank_sel_i[m] == BANK_SEL_WIDTH'(BANK_ID));
  end

  // search starts at the pointer and wraps around
  always_comb begin
    win_valid = 1'b0;
    win_idx   = rr_q;
    for (int k = 0; k < NUM_MASTERS; k++) begin
      cand = int'(rr_q) + k;
      if (cand >= NUM_MASTERS) begin
        cand = cand - NUM_MASTERS;
      end
      if (!win_valid && hit[cand]) begin
        win_valid = 1'b1;
        win_idx   = MASTER_IDX_WIDTH'(cand);
      end
    end
  end

  always_comb begin
    gnt_o = '0;
    if (win_valid && bank.ready) begin
      gnt_o[win_idx] = 1'b1;
    end
  end

  assign bank.req   = win_valid && bank.ready;
  assign bank.row   = row_i[win_idx];
  assign bank.we    = we_i[win_idx];
  assign bank.wdata = wdata_i[win_idx];
  assign bank.be    = be_i[win_idx];
  assign bank.amo   = tcdm_pkg::atop_to_amo(atop_i[win_idx]);

  // pointer moves past the master just served
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q <= '0;
    end else if (bank.req) begin
      if (win_idx == MASTER_IDX_WIDTH'(NUM_MASTERS - 1)) begin
        rr_q <= '0;
      end else begin
        rr_q <= win_idx + 1'b1;
      end
    end
  end

  // a master just served yields the bank to any other master waiting on it
  for (genvar m = 0; m < NUM_MASTERS; m++) begin : gen_rr_check
    a_rr_yield : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $past(rst_n_i) && $past(gnt_o[m]) && bank.ready &&
      (|(hit & ~(NUM_MASTERS'(1) << m))) |-> !gnt_o[m]);
  end

endmodule

// File: design/tcdm_master_port.sv
// one request in flight per master; the response has no back-pressure and must be taken
`timescale 1ns/1ps

module tcdm_master_port #(
  parameter int  NUM_BANKS      = 4,
  parameter int  DATA_WIDTH     = 32,
  parameter int  ADDR_WIDTH     = 32,
  parameter int  ROW_WIDTH      = 6,
  localparam int BANK_SEL_WIDTH = $clog2(NUM_BANKS),
  localparam int BE_WIDTH       = DATA_WIDTH / 8
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [ADDR_WIDTH-1:0]                addr_i,
  input  logic [DATA_WIDTH-1:0]                wdata_i,
  input  logic [BE_WIDTH-1:0]                  be_i,
  input  logic [tcdm_pkg::ATOP_WIDTH-1:0]      atop_i,
  output logic                                 bank_req_o,
  output logic [BANK_SEL_WIDTH-1:0]            bank_sel_o,
  output logic [ROW_WIDTH-1:0]                 row_o,
  input  logic [NUM_BANKS-1:0]                 bank_gnt_i,
  input  logic [NUM_BANKS-1:0][DATA_WIDTH-1:0] bank_rdata_i,
  output logic                                 gnt_o,
  output logic                                 r_valid_o,
  output logic [DATA_WIDTH-1:0]                r_rdata_o
);

  localparam int BYTE_OFF_WIDTH = $clog2(BE_WIDTH);

  logic [BANK_SEL_WIDTH-1:0] gnt_bank;
  logic [BANK_SEL_WIDTH-1:0] rsp_bank_q;
  logic                      rsp_valid_q;

  // word interleaved: offset, then bank, then row
  assign bank_req_o = req_i;
  assign bank_sel_o = addr_i[BYTE_OFF_WIDTH +: BANK_SEL_WIDTH];
  assign row_o      = addr_i[BYTE_OFF_WIDTH + BANK_SEL_WIDTH +: ROW_WIDTH];

  assign gnt_o = |bank_gnt_i;

  always_comb begin
    gnt_bank = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (bank_gnt_i[b]) begin
        gnt_bank = BANK_SEL_WIDTH'(b);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= gnt_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      rsp_bank_q <= gnt_bank;
    end
  end

  assign r_valid_o = rsp_valid_q;
  assign r_rdata_o = bank_rdata_i[rsp_bank_q];

  // only the addressed bank may grant, and never two at once
  a_gnt_from_own_bank : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(bank_gnt_i) && (gnt_o -> bank_gnt_i[bank_sel_o]));

  // a waiting master keeps its request and fields stable until granted
  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i && !gnt_o |=> req_i && $stable({addr_i, we_i, wdata_i, be_i, atop_i}));

endmodule

// File: design/tcdm_bank_if.sv
// one bank port; rdata is valid the cycle after req, ready drops during an atomic write-back
`timescale 1ns/1ps

interface tcdm_bank_if #(
  parameter int DATA_WIDTH = 32,
  parameter int ROW_WIDTH  = 6
);

  localparam int BE_WIDTH = DATA_WIDTH / 8;

  // request side, driven by the arbiter
  logic                  req;
  logic [ROW_WIDTH-1:0]  row;
  logic                  we;
  logic [DATA_WIDTH-1:0] wdata;
  logic [BE_WIDTH-1:0]   be;
  tcdm_pkg::amo_op_e     amo;

  // bank side
  logic                  ready;
  logic [DATA_WIDTH-1:0] rdata;

  modport arbiter (
    output req, row, we, wdata, be, amo,
    input  ready
  );

  modport bank (
    input  req, row, we, wdata, be, amo,
    output ready, rdata
  );

endinterface

// File: design/tcdm_pkg.sv
// atop encoding follows RISC-V funct5; LR/SC and unknown codes decode to a plain access
package tcdm_pkg;

  // bit 5 flags an atomic, bits 4..0 carry funct5
  localparam int ATOP_WIDTH = 6;

  localparam logic [4:0] ATOP_ADD  = 5'b00000;
  localparam logic [4:0] ATOP_SWAP = 5'b00001;
  localparam logic [4:0] ATOP_XOR  = 5'b00100;
  localparam logic [4:0] ATOP_OR   = 5'b01000;
  localparam logic [4:0] ATOP_AND  = 5'b01100;
  localparam logic [4:0] ATOP_MIN  = 5'b10000;
  localparam logic [4:0] ATOP_MAX  = 5'b10100;
  localparam logic [4:0] ATOP_MINU = 5'b11000;
  localparam logic [4:0] ATOP_MAXU = 5'b11100;

  // operation applied inside a bank
  typedef enum logic [3:0] {
    AMO_NONE = 4'h0,
    AMO_SWAP = 4'h1,
    AMO_ADD  = 4'h2,
    AMO_AND  = 4'h3,
    AMO_OR   = 4'h4,
    AMO_XOR  = 4'h5,
    AMO_MAX  = 4'h6,
    AMO_MAXU = 4'h7,
    AMO_MIN  = 4'h8,
    AMO_MINU = 4'h9
  } amo_op_e;

  function automatic amo_op_e atop_to_amo(input logic [ATOP_WIDTH-1:0] atop);
    amo_op_e op;
    op = AMO_NONE;
    if (atop[ATOP_WIDTH-1]) begin
      case (atop[4:0])
        ATOP_ADD:  op = AMO_ADD;
        ATOP_SWAP: op = AMO_SWAP;
        ATOP_XOR:  op = AMO_XOR;
        ATOP_OR:   op = AMO_OR;
        ATOP_AND:  op = AMO_AND;
        ATOP_MIN:  op = AMO_MIN;
        ATOP_MAX:  op = AMO_MAX;
        ATOP_MINU: op = AMO_MINU;
        ATOP_MAXU: op = AMO_MAXU;
        default:   op = AMO_NONE;
      endcase
    end
    return op;
  endfunction

endpackage
